//--- hw/aimbot_pkg.sv
`default_nettype none

package aimbot_pkg;

    // Size of one camera frame
    localparam int FRAME_W = 8;
    localparam int FRAME_H = 8;

    // Both camera pictures sit side by side on the display
    localparam int DISP_W = 2 * FRAME_W;

    localparam int ADDR_W = 8;

    // Region base of each camera in the frame memory
    localparam int CAM1_BASE = 0;
    localparam int CAM2_BASE = 64;

    typedef logic [ADDR_W-1:0] mem_addr_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } pixel565_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // Capture FIFO entry
    typedef struct packed {
        mem_addr_t addr;
        pixel565_t pix;
    } cam_write_t;

endpackage : aimbot_pkg

`default_nettype wire

//--- hw/mem_bus_if.sv
`default_nettype none

interface mem_bus_if;

    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    aimbot_pkg::mem_addr_t paddr;
    aimbot_pkg::pixel565_t pwdata;
    aimbot_pkg::pixel565_t prdata;  // Valid in the completing cycle of a read
    logic                  pready;

    modport requester (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready
    );

    modport completer (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready
    );

endinterface : mem_bus_if

`default_nettype wire

//--- hw/sync_fifo.sv
`default_nettype none

module sync_fifo #(
    parameter type entry_t = logic [15:0],
    parameter int  DEPTH   = 4
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop,
    output entry_t pop_data,
    output logic   full,
    output logic   empty
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    entry_t        buffer [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign do_push  = push && !full;  // Push when full is lost
    assign do_pop   = pop && !empty;
    assign full     = count == (PW+1)'(DEPTH);
    assign empty    = count == '0;
    assign pop_data = buffer[rd_ptr];  // Head shows without a pop

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            buffer[wr_ptr] <= push_data;
    end

endmodule : sync_fifo

`default_nettype wire

//--- hw/cam_capture.sv
`default_nettype none

module cam_capture #(
    parameter aimbot_pkg::mem_addr_t BASE_ADDR = '0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                vsync,
    input  logic                href,
    input  logic [7:0]          data,
    mem_bus_if.requester        mem,
    output logic                overflow
);

    localparam int N_PIX      = aimbot_pkg::FRAME_W * aimbot_pkg::FRAME_H;
    localparam int CW         = $clog2(N_PIX);
    localparam int FIFO_DEPTH = 4;

    logic                   phase;  // High after the first byte of a pair
    logic [7:0]             hi_byte;
    logic [CW-1:0]          pix_cnt;
    logic                   push;
    logic                   pop;
    logic                   full;
    logic                   empty;
    aimbot_pkg::cam_write_t push_data;
    aimbot_pkg::cam_write_t head;
    logic                   sel;
    logic                   enable;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase    <= 1'b0;
            pix_cnt  <= '0;
            push     <= 1'b0;
            overflow <= 1'b0;
        end else begin
            push <= 1'b0;
            if (vsync) begin  // New frame
                phase   <= 1'b0;
                pix_cnt <= '0;
            end else if (href) begin
                phase <= !phase;
                if (phase) begin
                    push    <= 1'b1;
                    pix_cnt <= (pix_cnt == CW'(N_PIX - 1)) ? '0 : pix_cnt + 1'b1;
                end
            end
            if (push && full)
                overflow <= 1'b1;  // Sticky
        end
    end

    // First byte is the high byte
    always_ff @(posedge clk) begin
        if (href && !phase)
            hi_byte <= data;
        if (href && phase) begin
            push_data.addr <= BASE_ADDR + aimbot_pkg::mem_addr_t'(pix_cnt);
            push_data.pix  <= aimbot_pkg::pixel565_t'({hi_byte, data});
        end
    end

    sync_fifo #(
        .entry_t(aimbot_pkg::cam_write_t),
        .DEPTH  (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk      ),
        .reset    (reset    ),
        .push     (push     ),
        .push_data(push_data),
        .pop      (pop      ),
        .pop_data (head     ),
        .full     (full     ),
        .empty    (empty    )
    );

    // Write handshake, one entry at a time
    always_ff @(posedge clk) begin
        if (reset) begin
            sel    <= 1'b0;
            enable <= 1'b0;
        end else if (!sel) begin
            sel <= !empty;
        end else if (!enable) begin
            enable <= 1'b1;
        end else if (mem.pready) begin
            sel    <= 1'b0;
            enable <= 1'b0;
        end
    end

    assign pop         = sel && enable && mem.pready;
    assign mem.psel    = sel;
    assign mem.penable = enable;
    assign mem.pwrite  = 1'b1;
    assign mem.paddr   = head.addr;
    assign mem.pwdata  = head.pix;

endmodule : cam_capture

`default_nettype wire

//--- hw/mem_arbiter.sv
`default_nettype none

module mem_arbiter #(
    parameter int N_PORTS = 3
) (
    input  logic         clk,
    input  logic         reset,
    mem_bus_if.completer req [N_PORTS],
    mem_bus_if.requester mem
);

    localparam int GW = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

    typedef enum logic [1:0] {ARB_IDLE, ARB_SETUP, ARB_ACCESS} arb_state_t;

    arb_state_t            state;
    logic [GW-1:0]         grant;  // Also the last winner
    logic [GW-1:0]         pick;
    logic                  found;
    logic [N_PORTS-1:0]    sel_vec;
    logic                  wr_vec    [N_PORTS];
    aimbot_pkg::mem_addr_t addr_vec  [N_PORTS];
    aimbot_pkg::pixel565_t wdata_vec [N_PORTS];
    logic                  wr_q;
    aimbot_pkg::mem_addr_t addr_q;
    aimbot_pkg::pixel565_t wdata_q;

    for (genvar i = 0; i < N_PORTS; i++) begin : g_port
        assign sel_vec[i]     = req[i].psel;
        assign wr_vec[i]      = req[i].pwrite;
        assign addr_vec[i]    = req[i].paddr;
        assign wdata_vec[i]   = req[i].pwdata;
        // Only the winner sees the completion
        assign req[i].pready  = (state == ARB_ACCESS) && mem.pready && (grant == GW'(i));
        assign req[i].prdata  = (grant == GW'(i)) ? mem.prdata : '0;
    end

    // Search starts after the last winner
    always_comb begin
        int idx;
        pick  = grant;
        found = 1'b0;
        for (int k = 1; k <= N_PORTS; k++) begin
            idx = (int'(grant) + k) % N_PORTS;
            if (!found && sel_vec[idx]) begin
                pick  = GW'(idx);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ARB_IDLE;
            grant <= GW'(N_PORTS - 1);  // Port 0 goes first
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (found) begin
                        state <= ARB_SETUP;
                        grant <= pick;
                    end
                end
                ARB_SETUP: state <= ARB_ACCESS;
                default: begin
                    if (mem.pready)
                        state <= ARB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && found) begin
            wr_q    <= wr_vec[pick];
            addr_q  <= addr_vec[pick];
            wdata_q <= wdata_vec[pick];
        end
    end

    assign mem.psel    = state != ARB_IDLE;
    assign mem.penable = state == ARB_ACCESS;
    assign mem.pwrite  = wr_q;
    assign mem.paddr   = addr_q;
    assign mem.pwdata  = wdata_q;

endmodule : mem_arbiter

`default_nettype wire

//--- hw/frame_mem.sv
`default_nettype none

module frame_mem #(
    parameter int DEPTH = 128
) (
    input  logic         clk,
    mem_bus_if.completer bus
);

    localparam int AW = $clog2(DEPTH);

    aimbot_pkg::pixel565_t words [DEPTH];
    aimbot_pkg::pixel565_t rdata_q;

    initial begin
        for (int i = 0; i < DEPTH; i++)
            words[i] = '0;
    end

    always_ff @(posedge clk) begin
        if (bus.psel && !bus.penable)
            rdata_q <= words[bus.paddr[AW-1:0]];  // Read in setup
        if (bus.psel && bus.penable && bus.pwrite)
            words[bus.paddr[AW-1:0]] <= bus.pwdata;
    end

    assign bus.prdata = rdata_q;
    assign bus.pready = 1'b1;  // No wait states

endmodule : frame_mem

`default_nettype wire

//--- hw/video_timing.sv
`default_nettype none

module video_timing #(
    parameter int H_FP   = 16,
    parameter int H_SYNC = 16,
    parameter int H_BP   = 32,
    parameter int V_FP   = 2,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 4
) (
    input  logic                                   clk,
    input  logic                                   reset,
    output logic                                   hsync,
    output logic                                   vsync,
    output logic                                   de,
    output logic [$clog2(aimbot_pkg::DISP_W)-1:0]  x,
    output logic [$clog2(aimbot_pkg::FRAME_H)-1:0] y
);

    localparam int H_ACT   = aimbot_pkg::DISP_W;
    localparam int V_ACT   = aimbot_pkg::FRAME_H;
    localparam int H_TOTAL = H_ACT + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACT + V_FP + V_SYNC + V_BP;

    logic [$clog2(H_TOTAL)-1:0] h_cnt;
    logic [$clog2(V_TOTAL)-1:0] v_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_TOTAL - 1) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_TOTAL - 1) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Active, front porch, sync, back porch
    assign de    = (h_cnt < H_ACT) && (v_cnt < V_ACT);
    assign hsync = (h_cnt >= H_ACT + H_FP) && (h_cnt < H_ACT + H_FP + H_SYNC);
    assign vsync = (v_cnt >= V_ACT + V_FP) && (v_cnt < V_ACT + V_FP + V_SYNC);

    assign x = h_cnt[$bits(x)-1:0];  // Meaningful only while de
    assign y = v_cnt[$bits(y)-1:0];

endmodule : video_timing

`default_nettype wire

//--- hw/display_reader.sv
`default_nettype none

module display_reader (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   de,
    input  logic [$clog2(aimbot_pkg::DISP_W)-1:0]  x,
    input  logic [$clog2(aimbot_pkg::FRAME_H)-1:0] y,
    input  logic [4:0]                             box_x,
    input  logic [4:0]                             box_y,
    input  logic [4:0]                             box_w,
    input  logic [4:0]                             box_h,
    mem_bus_if.requester                           mem,
    output logic [7:0]                             r,
    output logic [7:0]                             g,
    output logic [7:0]                             b,
    output logic                                   underflow
);

    localparam int FRAME_W = aimbot_pkg::FRAME_W;
    localparam int DISP_W  = aimbot_pkg::DISP_W;
    localparam int FRAME_H = aimbot_pkg::FRAME_H;

    logic [$bits(x)-1:0]   fx;  // Fetch position
    logic [$bits(y)-1:0]   fy;
    int                    addr_i;
    logic                  sel;
    logic                  enable;
    logic                  push;
    logic                  pop;
    logic                  full;
    logic                  empty;
    logic                  armed;
    aimbot_pkg::pixel565_t head;
    aimbot_pkg::pixel565_t src;
    aimbot_pkg::rgb888_t   pix_q;
    logic                  box_hit;

    always_comb begin
        if (int'(fx) < FRAME_W)
            addr_i = aimbot_pkg::CAM1_BASE + int'(fy) * FRAME_W + int'(fx);
        else
            addr_i = aimbot_pkg::CAM2_BASE + int'(fy) * FRAME_W + int'(fx) - FRAME_W;
    end

    // Read handshake, paused while the FIFO is full
    always_ff @(posedge clk) begin
        if (reset) begin
            sel    <= 1'b0;
            enable <= 1'b0;
            fx     <= '0;
            fy     <= '0;
        end else if (!sel) begin
            sel <= !full;
        end else if (!enable) begin
            enable <= 1'b1;
        end else if (mem.pready) begin
            sel    <= 1'b0;
            enable <= 1'b0;
            if (fx == $bits(fx)'(DISP_W - 1)) begin
                fx <= '0;
                fy <= (fy == $bits(fy)'(FRAME_H - 1)) ? '0 : fy + 1'b1;
            end else begin
                fx <= fx + 1'b1;
            end
        end
    end

    assign push        = sel && enable && mem.pready;
    assign mem.psel    = sel;
    assign mem.penable = enable;
    assign mem.pwrite  = 1'b0;
    assign mem.paddr   = aimbot_pkg::mem_addr_t'(addr_i);
    assign mem.pwdata  = '0;

    sync_fifo #(
        .entry_t(aimbot_pkg::pixel565_t),
        .DEPTH  (32)
    ) u_fifo (
        .clk      (clk       ),
        .reset    (reset     ),
        .push     (push      ),
        .push_data(mem.prdata),
        .pop      (pop       ),
        .pop_data (head      ),
        .full     (full      ),
        .empty    (empty     )
    );

    // Popping starts with the first full frame after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            armed     <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (de && x == $bits(x)'(DISP_W - 1) && y == $bits(y)'(FRAME_H - 1))
                armed <= 1'b1;
            if (de && armed && empty)
                underflow <= 1'b1;
        end
    end

    assign pop = de && armed && !empty;
    assign src = (armed && !empty) ? head : '0;

    // Outline of the aiming box
    assign box_hit =
        ((int'(x) >= int'(box_x)) && (int'(x) <= int'(box_x) + int'(box_w) - 1) &&
         ((int'(y) == int'(box_y)) || (int'(y) == int'(box_y) + int'(box_h) - 1))) ||
        ((int'(y) >= int'(box_y)) && (int'(y) <= int'(box_y) + int'(box_h) - 1) &&
         ((int'(x) == int'(box_x)) || (int'(x) == int'(box_x) + int'(box_w) - 1)));

    always_ff @(posedge clk) begin
        if (!de)
            pix_q <= '0;
        else if (box_hit)
            pix_q <= '{r: 8'hff, g: 8'h00, b: 8'h00};
        else
            pix_q <= '{r: {src.r, src.r[4:2]}, g: {src.g, src.g[5:4]}, b: {src.b, src.b[4:2]}};
    end

    assign r = pix_q.r;
    assign g = pix_q.g;
    assign b = pix_q.b;

endmodule : display_reader

`default_nettype wire

//--- hw/aimbot_top.sv
`default_nettype none

module aimbot_top #(
    parameter int H_FP   = 16,
    parameter int H_SYNC = 16,
    parameter int H_BP   = 32,
    parameter int V_FP   = 2,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 4
) (
    input  logic       clk,
    input  logic       reset,

    input  logic       cam1_vsync,
    input  logic       cam1_href,
    input  logic [7:0] cam1_data,
    input  logic       cam2_vsync,
    input  logic       cam2_href,
    input  logic [7:0] cam2_data,

    input  logic [4:0] box_x,
    input  logic [4:0] box_y,
    input  logic [4:0] box_w,
    input  logic [4:0] box_h,

    output logic       hdmi_hsync,
    output logic       hdmi_vsync,
    output logic       hdmi_de,
    output logic [7:0] hdmi_r,
    output logic [7:0] hdmi_g,
    output logic [7:0] hdmi_b,

    output logic       cam1_overflow,
    output logic       cam2_overflow,
    output logic       disp_underflow
);

    logic [$clog2(aimbot_pkg::DISP_W)-1:0]  x;
    logic [$clog2(aimbot_pkg::FRAME_H)-1:0] y;
    logic                                   hsync;
    logic                                   vsync;
    logic                                   de;

    mem_bus_if req_bus [3] ();  // cam1, cam2, display
    mem_bus_if mem_bus ();

    cam_capture #(.BASE_ADDR(aimbot_pkg::mem_addr_t'(aimbot_pkg::CAM1_BASE))) u_cam1 (
        .clk     (clk          ),
        .reset   (reset        ),
        .vsync   (cam1_vsync   ),
        .href    (cam1_href    ),
        .data    (cam1_data    ),
        .mem     (req_bus[0]   ),
        .overflow(cam1_overflow)
    );

    cam_capture #(.BASE_ADDR(aimbot_pkg::mem_addr_t'(aimbot_pkg::CAM2_BASE))) u_cam2 (
        .clk     (clk          ),
        .reset   (reset        ),
        .vsync   (cam2_vsync   ),
        .href    (cam2_href    ),
        .data    (cam2_data    ),
        .mem     (req_bus[1]   ),
        .overflow(cam2_overflow)
    );

    mem_arbiter #(.N_PORTS(3)) u_arbiter (
        .clk  (clk    ),
        .reset(reset  ),
        .req  (req_bus),
        .mem  (mem_bus)
    );

    frame_mem #(.DEPTH(2 * aimbot_pkg::FRAME_W * aimbot_pkg::FRAME_H)) u_frame_mem (
        .clk(clk    ),
        .bus(mem_bus)
    );

    video_timing #(
        .H_FP  (H_FP  ),
        .H_SYNC(H_SYNC),
        .H_BP  (H_BP  ),
        .V_FP  (V_FP  ),
        .V_SYNC(V_SYNC),
        .V_BP  (V_BP  )
    ) u_timing (
        .clk  (clk  ),
        .reset(reset),
        .hsync(hsync),
        .vsync(vsync),
        .de   (de   ),
        .x    (x    ),
        .y    (y    )
    );

    display_reader u_reader (
        .clk      (clk           ),
        .reset    (reset         ),
        .de       (de            ),
        .x        (x             ),
        .y        (y             ),
        .box_x    (box_x         ),
        .box_y    (box_y         ),
        .box_w    (box_w         ),
        .box_h    (box_h         ),
        .mem      (req_bus[2]    ),
        .r        (hdmi_r        ),
        .g        (hdmi_g        ),
        .b        (hdmi_b        ),
        .underflow(disp_underflow)
    );

    // Match the reader's output register
    always_ff @(posedge clk) begin
        if (reset) begin
            hdmi_hsync <= 1'b0;
            hdmi_vsync <= 1'b0;
            hdmi_de    <= 1'b0;
        end else begin
            hdmi_hsync <= hsync;
            hdmi_vsync <= vsync;
            hdmi_de    <= de;
        end
    end

endmodule : aimbot_top

`default_nettype wire

//--- test/tb_aimbot.sv
`default_nettype none

module tb_aimbot;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_FP    = 16;
    localparam int H_SYNC  = 16;
    localparam int H_BP    = 32;
    localparam int V_FP    = 2;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 4;
    localparam int FRAME_W = aimbot_pkg::FRAME_W;
    localparam int FRAME_H = aimbot_pkg::FRAME_H;
    localparam int DISP_W  = aimbot_pkg::DISP_W;
    localparam int N_PIX   = FRAME_W * FRAME_H;
    localparam int SETTLE  = 20;  // Last capture write reaches memory well inside this

    localparam int H_TOTAL      = DISP_W + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL      = FRAME_H + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // Worst case display frames over all test steps, slowest camera streams included
    localparam int RUN_FRAMES   = 26;
    localparam int TIMEOUT_NS   = 2 * RUN_FRAMES * FRAME_CYCLES * 10;

    logic       clk = 1'b0;
    logic       reset;
    logic       cam1_vsync;
    logic       cam1_href;
    logic [7:0] cam1_data;
    logic       cam2_vsync;
    logic       cam2_href;
    logic [7:0] cam2_data;
    logic [4:0] box_x;
    logic [4:0] box_y;
    logic [4:0] box_w;
    logic [4:0] box_h;
    logic       hdmi_hsync;
    logic       hdmi_vsync;
    logic       hdmi_de;
    logic [7:0] hdmi_r;
    logic [7:0] hdmi_g;
    logic [7:0] hdmi_b;
    logic       cam1_overflow;
    logic       cam2_overflow;
    logic       disp_underflow;

    logic [31:0]           rng_state = 32'h34d;
    aimbot_pkg::pixel565_t cam_ref [2][N_PIX];  // Expected memory contents per camera
    logic [7:0]            cam1_bytes [$];
    logic [7:0]            cam2_bytes [$];
    int                    out_pos = -1;  // Raster position seen at the video outputs

    aimbot_top #(
        .H_FP  (H_FP  ),
        .H_SYNC(H_SYNC),
        .H_BP  (H_BP  ),
        .V_FP  (V_FP  ),
        .V_SYNC(V_SYNC),
        .V_BP  (V_BP  )
    ) aimbot_top_i (
        .clk           (clk           ),
        .reset         (reset         ),
        .cam1_vsync    (cam1_vsync    ),
        .cam1_href     (cam1_href     ),
        .cam1_data     (cam1_data     ),
        .cam2_vsync    (cam2_vsync    ),
        .cam2_href     (cam2_href     ),
        .cam2_data     (cam2_data     ),
        .box_x         (box_x         ),
        .box_y         (box_y         ),
        .box_w         (box_w         ),
        .box_h         (box_h         ),
        .hdmi_hsync    (hdmi_hsync    ),
        .hdmi_vsync    (hdmi_vsync    ),
        .hdmi_de       (hdmi_de       ),
        .hdmi_r        (hdmi_r        ),
        .hdmi_g        (hdmi_g        ),
        .hdmi_b        (hdmi_b        ),
        .cam1_overflow (cam1_overflow ),
        .cam2_overflow (cam2_overflow ),
        .disp_underflow(disp_underflow)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1);
    endtask

    // Picture the display should show at one raster position
    function automatic aimbot_pkg::rgb888_t expected_pixel(input int px, input int py);
        aimbot_pkg::pixel565_t p;
        aimbot_pkg::rgb888_t   e;
        int                    x0;
        int                    x1;
        int                    y0;
        int                    y1;
        bit                    outline;
        x0 = int'(box_x);
        x1 = x0 + int'(box_w) - 1;
        y0 = int'(box_y);
        y1 = y0 + int'(box_h) - 1;
        outline = ((px >= x0) && (px <= x1) && ((py == y0) || (py == y1))) ||
                  ((py >= y0) && (py <= y1) && ((px == x0) || (px == x1)));
        if (outline) begin
            e = '{r: 8'hff, g: 8'h00, b: 8'h00};
            return e;
        end
        if (px < FRAME_W)
            p = cam_ref[0][py * FRAME_W + px];
        else
            p = cam_ref[1][py * FRAME_W + px - FRAME_W];  // Right half is cam2
        e.r = {p.r, p.r[4:2]};
        e.g = {p.g, p.g[5:4]};
        e.b = {p.b, p.b[4:2]};
        return e;
    endfunction

    task automatic check_pixel(input aimbot_pkg::rgb888_t got, input aimbot_pkg::rgb888_t exp,
                               input int px, input int py);
        if (got !== exp)
            report_failure($sformatf("** Error at %0t ns: pixel (%0d,%0d) is %06h, expected %06h",
                                     $time, px, py, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("** Error at %0t ns: %s is %b, expected %b",
                                     $time, name, got, exp));
    endtask

    task automatic check_flags();
        check_flag("cam1_overflow", cam1_overflow, 1'b0);
        check_flag("cam2_overflow", cam2_overflow, 1'b0);
        check_flag("disp_underflow", disp_underflow, 1'b0);
    endtask

    // Outputs trail the raster by one register
    always @(posedge clk) begin
        if (reset)
            out_pos <= -1;
        else
            out_pos <= out_pos + 1;
    end

    // Sync and de levels for the position now at the outputs
    task automatic check_sync();
        int   h;
        int   v;
        logic de_exp;
        logic hs_exp;
        logic vs_exp;
        de_exp = 1'b0;
        hs_exp = 1'b0;
        vs_exp = 1'b0;
        if (out_pos >= 0) begin
            h = out_pos % H_TOTAL;
            v = (out_pos / H_TOTAL) % V_TOTAL;
            de_exp = (h < DISP_W) && (v < FRAME_H);
            hs_exp = (h >= DISP_W + H_FP) && (h < DISP_W + H_FP + H_SYNC);
            vs_exp = (v >= FRAME_H + V_FP) && (v < FRAME_H + V_FP + V_SYNC);
        end
        check_flag("hdmi_de", hdmi_de, de_exp);
        check_flag("hdmi_hsync", hdmi_hsync, hs_exp);
        check_flag("hdmi_vsync", hdmi_vsync, vs_exp);
    endtask

    always @(negedge clk) check_sync();

    // Returns on the falling edge after hdmi_vsync rises
    task automatic wait_vsync();
        logic prev;
        do begin
            prev = hdmi_vsync;
            @(negedge clk);
        end while (!(hdmi_vsync && !prev));
    endtask

    task automatic set_box(input int bx, input int by, input int bw, input int bh);
        wait_vsync();  // Box only moves in blanking
        box_x = 5'(bx);
        box_y = 5'(by);
        box_w = 5'(bw);
        box_h = 5'(bh);
    endtask

    task automatic random_box();
        int bx;
        int by;
        int bw;
        int bh;
        bx = int'(next_random() % 20);
        by = int'(next_random() % 10);
        bw = 1 + int'(next_random() % 16);
        bh = 1 + int'(next_random() % 8);
        set_box(bx, by, bw, bh);
    endtask

    // Whole active frame, starting with the first de after a vsync edge
    task automatic check_frame();
        int                  n;
        aimbot_pkg::rgb888_t got;
        n = 0;
        while (n < DISP_W * FRAME_H) begin
            @(negedge clk);
            if (hdmi_de) begin
                got = '{r: hdmi_r, g: hdmi_g, b: hdmi_b};
                check_pixel(got, expected_pixel(n % DISP_W, n / DISP_W), n % DISP_W, n / DISP_W);
                n++;
            end
        end
    endtask

    task automatic queue_frame(input int cam, input int n_pix, input bit half_pixel);
        logic [31:0]           rv;
        aimbot_pkg::pixel565_t p;
        for (int i = 0; i < n_pix; i++) begin
            rv = next_random();
            p = rv[15:0];
            cam_ref[cam][i] = p;
            if (cam == 0) begin
                cam1_bytes.push_back(p[15:8]);  // High byte first
                cam1_bytes.push_back(p[7:0]);
            end else begin
                cam2_bytes.push_back(p[15:8]);
                cam2_bytes.push_back(p[7:0]);
            end
        end
        if (half_pixel) begin
            rv = next_random();
            if (cam == 0)
                cam1_bytes.push_back(rv[7:0]);
            else
                cam2_bytes.push_back(rv[7:0]);
        end
    endtask

    // Plays the queued bytes with gaps of 8 to 15 cycles
    task automatic stream_bytes(input bit pulse1, input bit pulse2);
        int gap1;
        int gap2;
        gap1 = 0;
        gap2 = 0;
        @(negedge clk);
        cam1_vsync = pulse1;
        cam2_vsync = pulse2;
        repeat (2) @(negedge clk);
        cam1_vsync = 1'b0;
        cam2_vsync = 1'b0;
        while (cam1_bytes.size() > 0 || cam2_bytes.size() > 0) begin
            @(negedge clk);
            cam1_href = 1'b0;
            cam2_href = 1'b0;
            if (cam1_bytes.size() > 0) begin
                if (gap1 == 0) begin
                    cam1_href = 1'b1;
                    cam1_data = cam1_bytes.pop_front();
                    gap1 = 7 + int'(next_random() % 8);
                end else begin
                    gap1--;
                end
            end
            if (cam2_bytes.size() > 0) begin
                if (gap2 == 0) begin
                    cam2_href = 1'b1;
                    cam2_data = cam2_bytes.pop_front();
                    gap2 = 7 + int'(next_random() % 8);
                end else begin
                    gap2--;
                end
            end
        end
        @(negedge clk);
        cam1_href = 1'b0;
        cam2_href = 1'b0;
        repeat (SETTLE) @(negedge clk);
    endtask

    initial begin
        #(TIMEOUT_NS);
        report_failure("Timeout: the test did not finish in the expected number of frames");
    end

    initial begin
        reset      = 1'b1;
        cam1_vsync = 1'b0;
        cam1_href  = 1'b0;
        cam1_data  = '0;
        cam2_vsync = 1'b0;
        cam2_href  = 1'b0;
        cam2_data  = '0;
        box_x      = '0;
        box_y      = '0;
        box_w      = '0;
        box_h      = '0;
        for (int i = 0; i < N_PIX; i++) begin
            cam_ref[0][i] = '0;
            cam_ref[1][i] = '0;
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // Empty memory shows black around the box
        set_box(5, 2, 6, 4);
        check_frame();
        check_flags();

        // Prefetched lines may predate the writes, so one frame is skipped
        queue_frame(0, N_PIX, 1'b0);
        queue_frame(1, N_PIX, 1'b0);
        stream_bytes(1'b1, 1'b1);
        wait_vsync();
        random_box();
        check_frame();
        check_flags();

        set_box(0, 0, 16, 8);
        check_frame();
        set_box(14, 6, 6, 5);   // Clipped right and bottom
        check_frame();
        set_box(7, 3, 1, 4);
        check_frame();
        set_box(2, 5, 10, 1);
        check_frame();
        repeat (4) begin
            random_box();
            check_frame();
        end
        check_flags();

        queue_frame(1, N_PIX, 1'b0);
        stream_bytes(1'b0, 1'b1);
        wait_vsync();
        set_box(3, 1, 4, 3);
        check_frame();
        check_flags();

        // Partial frame with a dangling byte, then a restart
        queue_frame(0, 20, 1'b1);
        stream_bytes(1'b1, 1'b0);
        queue_frame(0, N_PIX, 1'b0);
        stream_bytes(1'b1, 1'b0);
        wait_vsync();
        random_box();
        check_frame();
        check_flags();

        $display("Everything OK");
        $finish;
    end

endmodule : tb_aimbot

`default_nettype wire

//--- filelist.f
hw/aimbot_pkg.sv
hw/mem_bus_if.sv
hw/sync_fifo.sv
hw/cam_capture.sv
hw/mem_arbiter.sv
hw/frame_mem.sv
hw/video_timing.sv
hw/display_reader.sv
hw/aimbot_top.sv
test/tb_aimbot.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_aimbot -f filelist.f -Mdir obj_dir -o tb_aimbot
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_aimbot > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "RESULT: FAIL"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "RESULT: FAIL (simulator exit status $run_status)"
    exit 1
fi

echo "RESULT: PASS"
exit 0
